// ==== rtl/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    typedef logic [3:0]  digit_t;
    typedef logic [11:0] code_t;      // oldest digit in top nibble
    typedef logic [7:0]  secs_t;      // two bcd digits

    typedef enum logic [2:0] {
        KEY_DIGIT,
        KEY_ENTER,
        KEY_BACK,
        KEY_CLEAR,
        KEY_SET
    } key_kind_t;

    typedef enum logic [1:0] {
        ENTRY,
        SET_ENTRY,
        OPEN,
        LOCKOUT
    } lock_state_t;

    typedef struct packed {
        logic      valid;
        key_kind_t kind;
        digit_t    digit;
    } key_evt_t;

    typedef struct packed {
        code_t      value;
        logic [1:0] count;            // digits held
    } entry_t;

    localparam digit_t DIGIT_BLANK = 4'hF;
    localparam code_t  CODE_BLANK  = {3{DIGIT_BLANK}};
    localparam code_t  GLYPH_PASS  = 12'hBCC;
    localparam code_t  GLYPH_SET   = 12'hDDD;
    localparam code_t  RESET_CODE  = 12'h246;
    localparam int     MAX_TRIES   = 3;

    // lockout start per lockout count, last entry repeats
    localparam logic [3:0][7:0] LOCKOUT_SECS = {8'h60, 8'h20, 8'h10, 8'h05};

    // keypad bit positions of the command keys
    localparam int KEY_BIT_ENTER = 0;
    localparam int KEY_BIT_SET   = 4;
    localparam int KEY_BIT_CLEAR = 8;
    localparam int KEY_BIT_BACK  = 12;

    localparam logic [15:0] KEY_MAP_MASK = 16'hFFF9;   // bits 1 and 2 unused
    // digit per keypad bit, F where no digit
    localparam logic [15:0][3:0] KEY_DIGIT_MAP = 64'h789F_456F_123F_0FFF;

    localparam logic [2:0] DISP_ENTRY = 3'd0;
    localparam logic [2:0] DISP_PASS  = 3'd1;
    localparam logic [2:0] DISP_SET   = 3'd2;
    localparam logic [2:0] DISP_BLANK = 3'd3;
    localparam logic [2:0] DISP_LOCK  = 3'd4;

endpackage

`default_nettype wire

// ==== rtl/tone_pkg.sv ====
`default_nettype none

package tone_pkg;

    localparam int SEC_CYCLES = 100;   // one simulated second

    typedef logic [$clog2(SEC_CYCLES)-1:0] presc_t;
    typedef logic [7:0] tone_cnt_t;

    typedef enum logic [1:0] {
        TONE_CLICK,
        TONE_PASS,
        TONE_FAIL,
        TONE_TICK
    } tone_sel_t;

    typedef struct packed {
        logic      req;
        tone_sel_t sel;
    } tone_req_t;

    // indexed by tone_sel_t
    localparam logic [3:0][7:0] TONE_HALF = {8'd4, 8'd8, 8'd2, 8'd4};
    localparam logic [3:0][7:0] TONE_LEN  = {8'd10, 8'd40, 8'd60, 8'd20};

    // fail tone is quiet over its middle quarter
    localparam tone_cnt_t FAIL_QUIET_LO = 8'd15;
    localparam tone_cnt_t FAIL_QUIET_HI = 8'd25;

endpackage

`default_nettype wire

// ==== rtl/keypad_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module keypad_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [15:0]        keypad,
    output lock_pkg::key_evt_t key_evt
);
    import lock_pkg::*;

    logic [15:0] kp_q;            // sampled keypad word
    logic [15:0] kp_prev;
    logic        one_hot;
    logic        mapped;
    key_evt_t    evt_d;

    assign one_hot = (kp_q != 16'h0000) && ((kp_q & (kp_q - 16'd1)) == 16'h0000);
    assign mapped  = (kp_q & ~KEY_MAP_MASK) == 16'h0000;

    always_comb begin
        evt_d       = '0;
        evt_d.kind  = KEY_DIGIT;
        evt_d.digit = DIGIT_BLANK;
        for (int i = 0; i < 16; i++) begin
            if (kp_q[i]) begin
                evt_d.digit = KEY_DIGIT_MAP[i];
            end
        end
        if (kp_q[KEY_BIT_ENTER]) evt_d.kind = KEY_ENTER;
        else if (kp_q[KEY_BIT_SET]) evt_d.kind = KEY_SET;
        else if (kp_q[KEY_BIT_CLEAR]) evt_d.kind = KEY_CLEAR;
        else if (kp_q[KEY_BIT_BACK]) evt_d.kind = KEY_BACK;
        evt_d.valid = (kp_q != kp_prev) && one_hot && mapped;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kp_q    <= '0;
            kp_prev <= '0;
            key_evt <= '0;
        end else begin
            kp_q    <= keypad;
            kp_prev <= kp_q;
            key_evt <= evt_d;     // one cycle per new press
        end
    end

endmodule

`default_nettype wire

// ==== rtl/code_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_entry (
    input  logic               clk,
    input  logic               arst_n,
    input  lock_pkg::key_evt_t op,
    input  logic               clear,
    output lock_pkg::entry_t   entry
);
    import lock_pkg::*;

    logic wipe;

    assign wipe = clear || (op.valid && op.kind == KEY_CLEAR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry.value <= CODE_BLANK;
            entry.count <= 2'd0;
        end else if (wipe) begin
            entry.value <= CODE_BLANK;
            entry.count <= 2'd0;
        end else if (op.valid) begin
            case (op.kind)
                KEY_DIGIT: begin
                    if (entry.count != 2'd3) begin    // full entry ignores digits
                        entry.value <= {entry.value[7:0], op.digit};
                        entry.count <= entry.count + 2'd1;
                    end
                end
                KEY_BACK: begin
                    if (entry.count != 2'd0) begin
                        entry.value <= {DIGIT_BLANK, entry.value[11:4]};   // drop newest
                        entry.count <= entry.count - 2'd1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lock_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module lock_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  lock_pkg::key_evt_t  key_evt,
    input  lock_pkg::entry_t    entry,
    output lock_pkg::key_evt_t  entry_op,
    output logic                entry_clear,
    output logic                timer_start,
    output lock_pkg::secs_t     timer_secs,
    input  logic                remaining_done,
    input  logic                sec_tick,
    output tone_pkg::tone_req_t tone,
    input  logic                tone_ack,
    output logic [2:0]          disp_mode,
    output logic                unlocked
);
    import lock_pkg::*;
    import tone_pkg::*;

    lock_state_t state;
    code_t       stored_code;
    logic [1:0]  tries;
    logic [1:0]  lockouts;        // saturates at table end
    logic        pend_valid;      // pass or fail waiting for idle
    tone_sel_t   pend_sel;

    logic        editing;
    logic        enter_full;
    logic        match;
    logic        miss;
    logic        last_miss;
    logic        store;
    logic        set_key;
    logic        relock;
    logic        click;
    logic        alarm;
    tone_sel_t   alarm_sel;

    assign editing    = (state == ENTRY) || (state == SET_ENTRY);
    assign enter_full = key_evt.valid && key_evt.kind == KEY_ENTER && editing
                        && entry.count == 2'd3;
    assign match      = enter_full && state == ENTRY && entry.value == stored_code;
    assign miss       = enter_full && state == ENTRY && entry.value != stored_code;
    assign last_miss  = miss && tries == 2'(MAX_TRIES - 1);
    assign store      = enter_full && state == SET_ENTRY;
    assign set_key    = key_evt.valid && editing && key_evt.kind == KEY_SET;
    assign relock     = key_evt.valid && state == OPEN && key_evt.kind == KEY_CLEAR;

    always_comb begin
        entry_op       = key_evt;
        entry_op.valid = key_evt.valid && editing &&
                         (key_evt.kind == KEY_DIGIT || key_evt.kind == KEY_BACK ||
                          key_evt.kind == KEY_CLEAR);
    end

    assign entry_clear = enter_full || set_key || relock || (remaining_done && state == LOCKOUT);
    assign timer_start = last_miss;
    assign timer_secs  = LOCKOUT_SECS[lockouts];

    assign click     = entry_op.valid || set_key || enter_full || relock;
    assign alarm     = match || store || miss;
    assign alarm_sel = miss ? TONE_FAIL : TONE_PASS;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ENTRY;
            stored_code <= RESET_CODE;
            tries       <= 2'd0;
            lockouts    <= 2'd0;
            disp_mode   <= DISP_BLANK;
            unlocked    <= 1'b0;
        end else begin
            case (state)
                ENTRY: begin
                    if (match) begin
                        state     <= OPEN;
                        disp_mode <= DISP_PASS;
                        unlocked  <= 1'b1;
                        tries     <= 2'd0;
                    end else if (last_miss) begin
                        state     <= LOCKOUT;
                        disp_mode <= DISP_LOCK;
                        tries     <= 2'd0;
                        if (lockouts != 2'd3) lockouts <= lockouts + 2'd1;
                    end else if (miss) begin
                        disp_mode <= DISP_BLANK;
                        tries     <= tries + 2'd1;
                    end else if (set_key) begin
                        state     <= SET_ENTRY;
                        disp_mode <= DISP_SET;
                    end else if (entry_op.valid) begin
                        disp_mode <= DISP_ENTRY;
                    end
                end
                SET_ENTRY: begin
                    if (store) begin
                        stored_code <= entry.value;
                        state       <= ENTRY;
                        disp_mode   <= DISP_BLANK;
                        tries       <= 2'd0;
                    end else if (set_key) begin
                        disp_mode <= DISP_SET;     // restart set entry
                    end else if (entry_op.valid) begin
                        disp_mode <= DISP_ENTRY;
                    end
                end
                OPEN: begin
                    if (relock) begin
                        state     <= ENTRY;
                        disp_mode <= DISP_BLANK;
                        unlocked  <= 1'b0;
                    end
                end
                LOCKOUT: begin
                    if (remaining_done) begin
                        state     <= ENTRY;
                        disp_mode <= DISP_BLANK;
                    end
                end
                default: state <= ENTRY;
            endcase
        end
    end

    // four-phase tone handshake, busy drops clicks and ticks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tone.req   <= 1'b0;
            tone.sel   <= TONE_CLICK;
            pend_valid <= 1'b0;
            pend_sel   <= TONE_CLICK;
        end else begin
            if (alarm) begin
                pend_valid <= 1'b1;
                pend_sel   <= alarm_sel;
            end
            if (tone.req) begin
                if (tone_ack) tone.req <= 1'b0;
            end else if (!tone_ack) begin
                if (alarm || pend_valid) begin
                    tone.req   <= 1'b1;
                    tone.sel   <= alarm ? alarm_sel : pend_sel;
                    pend_valid <= 1'b0;
                end else if (sec_tick) begin
                    tone.req <= 1'b1;
                    tone.sel <= TONE_TICK;
                end else if (click) begin
                    tone.req <= 1'b1;
                    tone.sel <= TONE_CLICK;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lockout_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lockout_timer (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  lock_pkg::secs_t secs,
    output lock_pkg::secs_t remaining,
    output logic            sec_tick,
    output logic            done
);
    import tone_pkg::*;

    presc_t presc;
    logic   running;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= 8'h00;
            presc     <= '0;
            running   <= 1'b0;
            sec_tick  <= 1'b0;
            done      <= 1'b0;
        end else begin
            sec_tick <= 1'b0;
            done     <= 1'b0;
            if (start) begin
                remaining <= secs;
                presc     <= '0;
                running   <= 1'b1;
            end else if (running) begin
                if (presc == presc_t'(SEC_CYCLES - 1)) begin
                    presc    <= '0;
                    sec_tick <= 1'b1;
                    if (remaining[3:0] == 4'd0) begin
                        remaining <= {remaining[7:4] - 4'd1, 4'd9};   // borrow from tens
                    end else begin
                        remaining <= remaining - 8'd1;
                    end
                    if (remaining == 8'h01) begin       // last second
                        running <= 1'b0;
                        done    <= 1'b1;
                    end
                end else begin
                    presc <= presc + presc_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tone_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tone_gen (
    input  logic                clk,
    input  logic                arst_n,
    input  tone_pkg::tone_req_t tone,
    output logic                tone_ack,
    output logic                buzzer
);
    import tone_pkg::*;

    typedef enum logic [1:0] {
        TG_IDLE,
        TG_PLAY,
        TG_ACK
    } tg_state_t;

    tg_state_t state;
    tone_sel_t sel_q;
    tone_cnt_t len_cnt;
    tone_cnt_t half_cnt;
    logic      quiet;

    assign quiet = (sel_q == TONE_FAIL) && (len_cnt >= FAIL_QUIET_LO)
                   && (len_cnt < FAIL_QUIET_HI);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= TG_IDLE;
            sel_q    <= TONE_CLICK;
            len_cnt  <= '0;
            half_cnt <= '0;
            tone_ack <= 1'b0;
            buzzer   <= 1'b0;
        end else begin
            case (state)
                TG_IDLE: begin
                    if (tone.req) begin
                        sel_q    <= tone.sel;     // held for the whole pattern
                        len_cnt  <= '0;
                        half_cnt <= '0;
                        state    <= TG_PLAY;
                    end
                end
                TG_PLAY: begin
                    len_cnt <= len_cnt + 8'd1;
                    if (half_cnt == TONE_HALF[sel_q] - 8'd1) begin
                        half_cnt <= '0;
                        buzzer   <= quiet ? 1'b0 : ~buzzer;
                    end else begin
                        half_cnt <= half_cnt + 8'd1;
                        if (quiet) buzzer <= 1'b0;
                    end
                    if (len_cnt == TONE_LEN[sel_q] - 8'd1) begin
                        buzzer   <= 1'b0;
                        tone_ack <= 1'b1;
                        state    <= TG_ACK;
                    end
                end
                TG_ACK: begin
                    if (!tone.req) begin  // req dropped, close handshake
                        tone_ack <= 1'b0;
                        state    <= TG_IDLE;
                    end
                end
                default: state <= TG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/code_lock.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_lock (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [15:0]     keypad,
    output lock_pkg::code_t display,
    output logic            unlocked,
    output logic            buzzer
);
    import lock_pkg::*;
    import tone_pkg::*;

    key_evt_t   key_evt;
    key_evt_t   entry_op;
    entry_t     entry;
    logic       entry_clear;
    logic       timer_start;
    secs_t      timer_secs;
    secs_t      remaining;
    logic       sec_tick;
    logic       timer_done;
    tone_req_t  tone;
    logic       tone_ack;
    logic [2:0] disp_mode;

    keypad_decoder keypad_decoder_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .keypad  (keypad),
        .key_evt (key_evt)
    );

    code_entry code_entry_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (entry_op),
        .clear  (entry_clear),
        .entry  (entry)
    );

    lock_ctrl lock_ctrl_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .key_evt        (key_evt),
        .entry          (entry),
        .entry_op       (entry_op),
        .entry_clear    (entry_clear),
        .timer_start    (timer_start),
        .timer_secs     (timer_secs),
        .remaining_done (timer_done),
        .sec_tick       (sec_tick),
        .tone           (tone),
        .tone_ack       (tone_ack),
        .disp_mode      (disp_mode),
        .unlocked       (unlocked)
    );

    lockout_timer lockout_timer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (timer_start),
        .secs      (timer_secs),
        .remaining (remaining),
        .sec_tick  (sec_tick),
        .done      (timer_done)
    );

    tone_gen tone_gen_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .tone     (tone),
        .tone_ack (tone_ack),
        .buzzer   (buzzer)
    );

    always_comb begin
        case (disp_mode)
            DISP_ENTRY: display = entry.value;
            DISP_PASS:  display = GLYPH_PASS;
            DISP_SET:   display = GLYPH_SET;
            DISP_LOCK:  display = {DIGIT_BLANK, remaining};   // seconds right-aligned
            default:    display = CODE_BLANK;
        endcase
    end

endmodule

`default_nettype wire

// ==== bench/code_lock_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_lock_asserts (
    input  logic                  clk,
    input  logic                  arst_n,
    input  lock_pkg::lock_state_t state,
    input  logic                  unlocked,
    input  logic                  timer_start,
    input  tone_pkg::tone_req_t   tone,
    input  logic                  tone_ack
);
    import lock_pkg::*;

    int fail_count = 0;           // failed assertions so far

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(tone_ack) |-> tone.req)
        else begin
            fail_count++;
            $error("tone_ack rose without a tone request");
        end

    req_held_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
        tone.req && !tone_ack |=> tone.req && $stable(tone.sel))
        else begin
            fail_count++;
            $error("tone request dropped or changed before its ack");
        end

    locked_while_lockout: assert property (@(posedge clk) disable iff (!arst_n)
        state == LOCKOUT |-> !unlocked)
        else begin
            fail_count++;
            $error("lock is open during a lockout");
        end

    start_from_entry: assert property (@(posedge clk) disable iff (!arst_n)
        timer_start |-> state == ENTRY)
        else begin
            fail_count++;
            $error("lockout timer started outside the entry state");
        end

endmodule

bind lock_ctrl code_lock_asserts asserts_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .state       (state),
    .unlocked    (unlocked),
    .timer_start (timer_start),
    .tone        (tone),
    .tone_ack    (tone_ack)
);

`default_nettype wire

// ==== bench/code_lock_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_lock_tb;
    import lock_pkg::*;
    import tone_pkg::*;

    localparam int          TIMEOUT_CYCLES = 6000;
    localparam logic [31:0] LFSR_SEED      = 32'h41cf3a03;

    logic        clk;
    logic        arst_n;
    logic [15:0] keypad;
    code_t       display;
    logic        unlocked;
    logic        buzzer;

    logic [31:0] lfsr_state;
    int          cycles = 0;
    logic        pass_buzz_seen;
    code_t       stored;          // code the lock should hold

    code_lock code_lock_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .keypad   (keypad),
        .display  (display),
        .unlocked (unlocked),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run passed its cycle limit without finishing");
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // buzzer activity while the pass tone is being played
    always @(negedge clk) begin
        if (buzzer && code_lock_inst.tone.req && code_lock_inst.tone.sel == TONE_PASS) begin
            pass_buzz_seen = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (code_lock_inst.lock_ctrl_inst.asserts_inst.fail_count != 0) begin
            report_error("a bound protocol assertion failed");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic int digit_key_bit(input digit_t d);
        case (d)
            4'd0: return 3;
            4'd1: return 7;
            4'd2: return 6;
            4'd3: return 5;
            4'd4: return 11;
            4'd5: return 10;
            4'd6: return 9;
            4'd7: return 15;
            4'd8: return 14;
            default: return 13;
        endcase
    endfunction

    function automatic secs_t bcd_minus_one(input secs_t s);
        int n;
        n = s[7:4] * 10 + s[3:0] - 1;
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_fail(input string name, input logic [11:0] exp,
                               input logic [11:0] act);
        $display("[FAIL] %s: expected %03h, actual %03h", name, exp, act);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_display(input string name, input code_t exp);
        assert (display === exp) else report_fail(name, exp, display);
    endtask

    task automatic check_unlocked(input string name, input logic exp);
        assert (unlocked === exp) else report_fail(name, 12'(exp), 12'(unlocked));
    endtask

    task automatic wait_display(input string name, input code_t exp, input int limit);
        int n;
        n = 0;
        while (display !== exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        check_display(name, exp);
    endtask

    task automatic wait_pass_ack(input int limit);
        int n;
        n = 0;
        while (!(code_lock_inst.tone_ack && code_lock_inst.tone.sel == TONE_PASS)
               && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(code_lock_inst.tone_ack && code_lock_inst.tone.sel == TONE_PASS)) begin
            report_error("pass tone was never acknowledged");
        end
    endtask

    // called on a falling edge, returns on one
    task automatic press_key(input int key_bit);
        keypad[key_bit] = 1'b1;
        repeat (3) @(negedge clk);
        keypad = '0;
        repeat (3) @(negedge clk);
    endtask

    task automatic press_digit(input digit_t d);
        press_key(digit_key_bit(d));
    endtask

    task automatic enter_code(input code_t c);
        press_digit(c[11:8]);
        press_digit(c[7:4]);
        press_digit(c[3:0]);
        press_key(KEY_BIT_ENTER);
    endtask

    task automatic draw_digit(output digit_t d);
        logic [3:0] raw;
        raw = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            raw = {raw[2:0], lfsr_state[0]};
        end
        d = raw % 4'd10;
    endtask

    task automatic draw_code(output code_t c, input code_t avoid);
        digit_t d0;
        digit_t d1;
        digit_t d2;
        draw_digit(d0);
        draw_digit(d1);
        draw_digit(d2);
        if ({d0, d1, d2} == avoid) d2 = (d2 == 4'd9) ? 4'd0 : d2 + 4'd1;
        c = {d0, d1, d2};
    endtask

    task automatic miss_three(input string name);
        code_t wrong;
        for (int i = 0; i < 3; i++) begin
            draw_code(wrong, stored);
            enter_code(wrong);
            if (i < 2) begin
                check_display({name, " miss"}, CODE_BLANK);
                check_unlocked({name, " miss"}, 1'b0);
            end
        end
    endtask

    initial begin
        code_t new_code;
        secs_t secs_exp;
        keypad         = '0;
        arst_n         = 1'b0;
        lfsr_state     = LFSR_SEED;
        pass_buzz_seen = 1'b0;
        stored         = RESET_CODE;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_display("reset", CODE_BLANK);
        check_unlocked("reset", 1'b0);

        press_digit(4'd1);
        check_display("one digit", 12'hFF1);
        press_digit(4'd2);
        check_display("two digits", 12'hF12);
        press_digit(4'd3);
        check_display("three digits", 12'h123);
        press_digit(4'd4);
        check_display("fourth digit", 12'h123);
        press_key(KEY_BIT_BACK);
        check_display("backspace", 12'hF12);
        press_key(KEY_BIT_CLEAR);
        check_display("clear", CODE_BLANK);

        pass_buzz_seen = 1'b0;
        enter_code(stored);
        check_display("correct code", GLYPH_PASS);
        check_unlocked("correct code", 1'b1);
        wait_pass_ack(200);
        assert (pass_buzz_seen) else report_error("buzzer stayed silent during the pass tone");

        press_digit(4'd5);
        check_display("digit while open", GLYPH_PASS);
        press_key(KEY_BIT_CLEAR);
        check_display("relock", CODE_BLANK);
        check_unlocked("relock", 1'b0);

        miss_three("first lockout");
        check_display("first lockout start", {DIGIT_BLANK, 8'h05});
        check_unlocked("first lockout start", 1'b0);
        secs_exp = bcd_minus_one(8'h05);
        wait_display("lockout count", {DIGIT_BLANK, secs_exp}, SEC_CYCLES + 10);
        press_digit(4'd7);
        check_display("key during lockout", {DIGIT_BLANK, secs_exp});
        while (secs_exp != 8'h00) begin
            secs_exp = bcd_minus_one(secs_exp);
            wait_display("lockout count", {DIGIT_BLANK, secs_exp}, SEC_CYCLES + 10);
        end
        wait_display("lockout end", CODE_BLANK, 10);
        press_digit(4'd8);
        check_display("entry after lockout", 12'hFF8);
        press_key(KEY_BIT_CLEAR);

        miss_three("second lockout");
        check_display("second lockout start", {DIGIT_BLANK, 8'h10});
        wait_display("tens borrow", {DIGIT_BLANK, 8'h09}, SEC_CYCLES + 10);
        wait_display("second lockout end", CODE_BLANK, 10 * SEC_CYCLES + 20);

        press_key(KEY_BIT_SET);
        check_display("set mode", GLYPH_SET);
        draw_code(new_code, stored);
        press_digit(new_code[11:8]);
        press_digit(new_code[7:4]);
        press_digit(new_code[3:0]);
        check_display("new code entry", new_code);
        press_key(KEY_BIT_ENTER);
        check_display("code stored", CODE_BLANK);
        stored = new_code;
        enter_code(RESET_CODE);
        check_display("old code rejected", CODE_BLANK);
        check_unlocked("old code rejected", 1'b0);
        enter_code(stored);
        check_display("new code accepted", GLYPH_PASS);
        check_unlocked("new code accepted", 1'b1);
        press_key(KEY_BIT_CLEAR);
        check_unlocked("final relock", 1'b0);

        if (code_lock_inst.lock_ctrl_inst.asserts_inst.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== code_lock.f ====
rtl/lock_pkg.sv
rtl/tone_pkg.sv
rtl/keypad_decoder.sv
rtl/code_entry.sv
rtl/lock_ctrl.sv
rtl/lockout_timer.sv
rtl/tone_gen.sv
rtl/code_lock.sv
bench/code_lock_asserts.sv
bench/code_lock_tb.sv

// ==== Bender.yml ====
package:
  name: code_lock

sources:
  - files:
      - rtl/lock_pkg.sv
      - rtl/tone_pkg.sv
      - rtl/keypad_decoder.sv
      - rtl/code_entry.sv
      - rtl/lock_ctrl.sv
      - rtl/lockout_timer.sv
      - rtl/tone_gen.sv
      - rtl/code_lock.sv
  - target: test
    files:
      - bench/code_lock_asserts.sv
      - bench/code_lock_tb.sv
